//--- afu_control.sv
`timescale 1ns/1ns
`include "afu_params.svh"

module afu_control (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 enabled,
  input  afu_pkg::addr_t       wed,
  input  afu_pkg::buffer_in_t  buffer_in,
  input  afu_pkg::response_t   response,
  input  afu_pkg::descriptor_t desc,
  input  afu_pkg::addr_t       offset,
  input  logic                 last_chunk,
  input  logic                 both_done,
  output logic                 load,
  output logic                 clear,
  output logic                 advance,
  output logic                 capture,
  output logic                 stripe_clear,
  output afu_pkg::command_t    command
);

  import afu_pkg::*;

  afu_state_t state;
  afu_state_t next_state;
  command_t   cmd_next;
  logic       wed_resp;
  logic       parity_resp;
  logic       done_resp;

  assign wed_resp    = response.valid && response.tag == `TAG_WED;
  assign parity_resp = response.valid && response.tag == `TAG_PARITY;
  assign done_resp   = response.valid && response.tag == `TAG_DONE;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      IDLE:        if (enabled) next_state = WED_REQ;
      WED_REQ:     next_state = WED_WAIT;
      WED_WAIT:    if (wed_resp) next_state = READ_S1;
      READ_S1:     next_state = READ_S2;  // Both stripe reads back to back
      READ_S2:     next_state = STRIPE_WAIT;
      STRIPE_WAIT: if (both_done) next_state = WRITE_REQ;
      WRITE_REQ:   next_state = WRITE_WAIT;
      WRITE_WAIT: begin
        if (parity_resp) next_state = last_chunk ? DONE_REQ : READ_S1;
      end
      DONE_REQ:    next_state = DONE_WAIT;
      DONE_WAIT:   if (done_resp) next_state = FINISHED;
      FINISHED:    if (!enabled) next_state = IDLE;
      default:     next_state = IDLE;
    endcase
  end

  // Command fields for the request states, parity only on issue
  always_comb begin
    cmd_next = command;
    cmd_next.valid = 1'b0;
    case (state)
      WED_REQ: begin
        cmd_next.valid   = 1'b1;
        cmd_next.command = `CMD_READ_CL_NA;
        cmd_next.tag     = `TAG_WED;
        cmd_next.size    = `AFU_SIZE_W'(32);
        cmd_next.address = wed;
      end
      READ_S1, READ_S2: begin
        cmd_next.valid   = 1'b1;
        cmd_next.command = `CMD_READ_CL_S;
        cmd_next.tag     = (state == READ_S1) ? `TAG_STRIPE1 : `TAG_STRIPE2;
        cmd_next.size    = `AFU_SIZE_W'(`AFU_CHUNK_BYTES);
        cmd_next.address = ((state == READ_S1) ? desc.stripe1 : desc.stripe2) + offset;
      end
      WRITE_REQ: begin
        cmd_next.valid   = 1'b1;
        cmd_next.command = `CMD_WRITE_MS;
        cmd_next.tag     = `TAG_PARITY;
        cmd_next.size    = `AFU_SIZE_W'(`AFU_CHUNK_BYTES);
        cmd_next.address = desc.parity + offset;
      end
      DONE_REQ: begin
        cmd_next.valid   = 1'b1;
        cmd_next.command = `CMD_WRITE_MS;
        cmd_next.tag     = `TAG_DONE;
        cmd_next.size    = `AFU_SIZE_W'(1);
        cmd_next.address = wed + `AFU_STATUS_OFFSET;
      end
      default: ;
    endcase
    if (cmd_next.valid) begin
      cmd_next.command_parity = ~^cmd_next.command;
      cmd_next.tag_parity     = ~^cmd_next.tag;
      cmd_next.address_parity = ~^cmd_next.address;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      command <= '0;
    end else begin
      command <= cmd_next;
    end
  end

  assign clear        = (state == IDLE) && enabled;  // Fresh job registers
  assign load         = (state == WED_WAIT) && buffer_in.write_valid &&
                        buffer_in.write_tag == `TAG_WED && !buffer_in.write_address;
  assign advance      = (state == WRITE_WAIT) && parity_resp && !last_chunk;
  assign stripe_clear = (state == READ_S1);
  // Open from READ_S2 since a fast host may answer stripe 1 during it
  assign capture      = (state == READ_S2) || (state == STRIPE_WAIT);

  // Only the stripe pair goes out on consecutive cycles
  a_single_command: assert property (
    @(posedge clock) disable iff (reset)
    command.valid && $past(command.valid) |->
      command.tag == `TAG_STRIPE2 && $past(command.tag) == `TAG_STRIPE1
  ) else $error("afu_control: back-to-back commands outside stripe reads");

endmodule

//--- afu_params.svh
`ifndef AFU_PARAMS_SVH
`define AFU_PARAMS_SVH

// Bus and data widths
`define AFU_LINE_W        512   // One buffer transfer, half a chunk
`define AFU_CHUNK_W       1024  // One stripe chunk
`define AFU_CHUNK_BYTES   128
`define AFU_ADDR_W        64
`define AFU_TAG_W         8
`define AFU_CMD_W         13
`define AFU_SIZE_W        12

// Command tags, one per kind of transfer in flight
`define TAG_WED           8'h00
`define TAG_STRIPE1       8'h01
`define TAG_STRIPE2       8'h02
`define TAG_PARITY        8'h03
`define TAG_DONE          8'h04

// Host bus command codes
`define CMD_READ_CL_NA    13'h0A00
`define CMD_READ_CL_S     13'h0A50
`define CMD_WRITE_MS      13'h0D70

// Status byte lands here, relative to the descriptor
`define AFU_STATUS_OFFSET 32

`endif

//--- afu_pkg.sv
`include "afu_params.svh"

package afu_pkg;

  typedef logic [0:`AFU_ADDR_W-1]  addr_t;   // Big-endian bit order, bit 0 is MSB
  typedef logic [0:`AFU_LINE_W-1]  line_t;
  typedef logic [0:`AFU_CHUNK_W-1] chunk_t;

  typedef struct packed {
    logic                    valid;
    logic [0:`AFU_CMD_W-1]   command;
    logic                    command_parity;
    logic [0:`AFU_TAG_W-1]   tag;
    logic                    tag_parity;
    logic [0:`AFU_SIZE_W-1]  size;           // Transfer size in bytes
    addr_t                   address;
    logic                    address_parity;
  } command_t;

  typedef struct packed {
    logic                    write_valid;    // Read data coming back from host
    logic [0:`AFU_TAG_W-1]   write_tag;
    logic                    write_address;  // Which half of the chunk
    line_t                   write_data;
    logic                    read_valid;     // Host fetching write data
    logic [0:`AFU_TAG_W-1]   read_tag;
    logic                    read_address;
  } buffer_in_t;

  typedef struct packed {
    line_t                   read_data;
    logic                    read_parity;
  } buffer_out_t;

  typedef struct packed {
    logic                    valid;
    logic [0:`AFU_TAG_W-1]   tag;
  } response_t;

  typedef struct packed {
    addr_t                   size;
    addr_t                   stripe1;
    addr_t                   stripe2;
    addr_t                   parity;
  } descriptor_t;

  typedef enum logic [3:0] {
    IDLE,
    WED_REQ,
    WED_WAIT,
    READ_S1,
    READ_S2,
    STRIPE_WAIT,
    WRITE_REQ,
    WRITE_WAIT,
    DONE_REQ,
    DONE_WAIT,
    FINISHED
  } afu_state_t;

  // Descriptor words are stored little-endian in host memory
  function automatic addr_t swap_bytes(input addr_t word);
    addr_t swapped;
    for (int i = 0; i < 8; i++) begin
      swapped[i*8 +: 8] = word[(7-i)*8 +: 8];
    end
    return swapped;
  endfunction

endpackage

//--- host_model.sv
`timescale 1ns/1ns
`include "afu_params.svh"

module host_model #(
  parameter int MEM_LINES = 64,
  parameter int LOG_DEPTH = 32
) (
  input  logic                 clock,
  input  logic                 reset,
  input  afu_pkg::command_t    command,
  input  afu_pkg::buffer_out_t buffer_out,
  output afu_pkg::buffer_in_t  buffer_in,
  output afu_pkg::response_t   response
);

  import afu_pkg::*;

  typedef enum {H_IDLE, H_DELAY, H_DATA, H_RESP} host_state_t;

  line_t       mem [0:MEM_LINES-1];       // 64-byte lines, loaded by the testbench
  int          delays [0:63];             // 0 to 7 cycles each
  command_t    cmd_log [0:LOG_DEPTH-1];
  buffer_out_t read_log [0:LOG_DEPTH-1];  // Everything the unit returned on buffer reads
  int          cmd_count;
  int          read_count;
  int          jobs_done;

  host_state_t state;
  command_t    pending [$];
  command_t    cur;
  int          delay_index;
  int          wait_cycles;
  int          halves;
  int          half_count;
  logic        first_half;
  logic        read_pending;
  logic        read_half;

  function automatic int line_index(input addr_t address);
    return int'((address >> 6) % MEM_LINES);
  endfunction

  function automatic int next_delay();
    int d;
    d = delays[delay_index];
    delay_index = (delay_index + 1) % 64;
    return d;
  endfunction

  task automatic store_write(input command_t c, input logic half, input line_t data);
    int idx;
    int first;
    idx = line_index(c.address);
    first = int'(c.address % 64);
    if (c.size == `AFU_CHUNK_BYTES) begin
      mem[(idx + half) % MEM_LINES] = data;
    end else if (!half) begin
      for (int b = first; b < first + int'(c.size) && b < 64; b++) begin
        mem[idx][b*8 +: 8] = data[b*8 +: 8];  // Byte-enabled partial write
      end
    end
  endtask

  task automatic drive_half(input logic half);
    if (cur.command == `CMD_WRITE_MS) begin
      buffer_in.read_valid   = 1'b1;
      buffer_in.read_tag     = cur.tag;
      buffer_in.read_address = half;
      read_pending = 1'b1;
      read_half    = half;
    end else begin
      buffer_in.write_valid   = 1'b1;
      buffer_in.write_tag     = cur.tag;
      buffer_in.write_address = half;
      buffer_in.write_data    = mem[(line_index(cur.address) + half) % MEM_LINES];
    end
  endtask

  initial begin
    buffer_in    = '0;
    response     = '0;
    state        = H_IDLE;
    read_pending = 1'b0;
    delay_index  = 0;
    cmd_count    = 0;
    read_count   = 0;
    jobs_done    = 0;
  end

  // One command served at a time, stripe reads queue up behind each other
  always @(negedge clock) begin
    buffer_in.write_valid = 1'b0;
    buffer_in.read_valid  = 1'b0;
    response.valid        = 1'b0;
    if (reset) begin
      state = H_IDLE;
      pending.delete();
      read_pending = 1'b0;
    end else begin
      if (read_pending) begin  // Data due one cycle after read_valid
        if (read_count < LOG_DEPTH) read_log[read_count] = buffer_out;
        read_count++;
        store_write(cur, read_half, buffer_out.read_data);
        read_pending = 1'b0;
      end
      if (command.valid) begin
        if (cmd_count < LOG_DEPTH) cmd_log[cmd_count] = command;
        cmd_count++;
        pending.push_back(command);
      end
      case (state)
        H_IDLE: begin
          if (pending.size() > 0) begin
            cur = pending.pop_front();
            wait_cycles = next_delay();
            halves = (cur.command == `CMD_WRITE_MS || cur.size > 64) ? 2 : 1;
            first_half = (halves == 2) ? wait_cycles[0] : 1'b0;  // Random half order
            state = H_DELAY;
          end
        end
        H_DELAY: begin
          if (wait_cycles > 0) begin
            wait_cycles--;
          end else begin
            drive_half(first_half);
            half_count = 1;
            state = H_DATA;
          end
        end
        H_DATA: begin
          if (half_count < halves) begin
            drive_half(~first_half);
            half_count++;
          end else begin
            wait_cycles = next_delay();
            state = H_RESP;
          end
        end
        H_RESP: begin
          if (wait_cycles > 0) begin
            wait_cycles--;
          end else begin
            response.valid = 1'b1;
            response.tag   = cur.tag;
            if (cur.tag == `TAG_DONE) jobs_done++;
            state = H_IDLE;
          end
        end
      endcase
    end
  end

endmodule

//--- job_regs.sv
`timescale 1ns/1ns
`include "afu_params.svh"

module job_regs (
  input  logic                clock,
  input  logic                reset,
  input  logic                load,
  input  logic                clear,
  input  logic                advance,
  input  afu_pkg::line_t      write_data,
  output afu_pkg::descriptor_t desc,
  output afu_pkg::addr_t      offset,
  output logic                last_chunk
);

  import afu_pkg::*;

  addr_t next_offset;

  assign next_offset = offset + `AFU_CHUNK_BYTES;
  assign last_chunk  = next_offset >= desc.size;  // Current chunk reaches job end

  // Descriptor words sit in the first 32 bytes of half 0
  always_ff @(posedge clock) begin
    if (reset || clear) begin
      desc <= '0;
    end else if (load) begin
      desc.size    <= swap_bytes(write_data[0:63]);
      desc.stripe1 <= swap_bytes(write_data[64:127]);
      desc.stripe2 <= swap_bytes(write_data[128:191]);
      desc.parity  <= swap_bytes(write_data[192:255]);
    end
  end

  always_ff @(posedge clock) begin
    if (reset || clear) begin
      offset <= '0;
    end else if (advance) begin
      offset <= next_offset;  // Step to next chunk
    end
  end

  // The controller must stop advancing once the final chunk is written
  a_no_advance_past_end: assert property (
    @(posedge clock) disable iff (reset)
    advance |-> !last_chunk
  ) else $error("job_regs: advance past last chunk");

endmodule

//--- parity_afu.sv
`timescale 1ns/1ns

module parity_afu (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 enabled,
  input  afu_pkg::addr_t       wed,
  input  afu_pkg::buffer_in_t  buffer_in,
  input  afu_pkg::response_t   response,
  output afu_pkg::command_t    command,
  output afu_pkg::buffer_out_t buffer_out
);

  import afu_pkg::*;

  descriptor_t desc;
  addr_t       offset;
  logic        last_chunk;
  logic        both_done;
  logic        load;
  logic        clear;
  logic        advance;
  logic        capture;
  logic        stripe_clear;
  chunk_t      stripe1;
  chunk_t      stripe2;

  job_regs job_regs0 (
    .clock      (clock),
    .reset      (reset),
    .load       (load),
    .clear      (clear),
    .advance    (advance),
    .write_data (buffer_in.write_data),
    .desc       (desc),
    .offset     (offset),
    .last_chunk (last_chunk)
  );

  stripe_buffer stripe_buffer0 (
    .clock     (clock),
    .reset     (reset),
    .capture   (capture),
    .clear     (stripe_clear),
    .buffer_in (buffer_in),
    .response  (response),
    .stripe1   (stripe1),
    .stripe2   (stripe2),
    .both_done (both_done)
  );

  write_path write_path0 (
    .clock      (clock),
    .reset      (reset),
    .stripe1    (stripe1),
    .stripe2    (stripe2),
    .buffer_in  (buffer_in),
    .buffer_out (buffer_out)
  );

  afu_control afu_control0 (
    .clock        (clock),
    .reset        (reset),
    .enabled      (enabled),
    .wed          (wed),
    .buffer_in    (buffer_in),
    .response     (response),
    .desc         (desc),
    .offset       (offset),
    .last_chunk   (last_chunk),
    .both_done    (both_done),
    .load         (load),
    .clear        (clear),
    .advance      (advance),
    .capture      (capture),
    .stripe_clear (stripe_clear),
    .command      (command)
  );

endmodule

//--- sim.f
+incdir+.
afu_pkg.sv
job_regs.sv
stripe_buffer.sv
write_path.sv
afu_control.sv
parity_afu.sv
host_model.sv
tb_parity_afu.sv

//--- stripe_buffer.sv
`timescale 1ns/1ns
`include "afu_params.svh"

module stripe_buffer (
  input  logic                clock,
  input  logic                reset,
  input  logic                capture,
  input  logic                clear,
  input  afu_pkg::buffer_in_t buffer_in,
  input  afu_pkg::response_t  response,
  output afu_pkg::chunk_t     stripe1,
  output afu_pkg::chunk_t     stripe2,
  output logic                both_done
);

  import afu_pkg::*;

  logic received1;
  logic received2;
  logic stripe_write;

  assign stripe_write = buffer_in.write_valid &&
                        (buffer_in.write_tag == `TAG_STRIPE1 ||
                         buffer_in.write_tag == `TAG_STRIPE2);

  // Halves may arrive in either order
  always_ff @(posedge clock) begin
    if (capture && buffer_in.write_valid) begin
      case (buffer_in.write_tag)
        `TAG_STRIPE1: begin
          if (buffer_in.write_address) begin
            stripe1[`AFU_LINE_W:`AFU_CHUNK_W-1] <= buffer_in.write_data;
          end else begin
            stripe1[0:`AFU_LINE_W-1] <= buffer_in.write_data;
          end
        end
        `TAG_STRIPE2: begin
          if (buffer_in.write_address) begin
            stripe2[`AFU_LINE_W:`AFU_CHUNK_W-1] <= buffer_in.write_data;
          end else begin
            stripe2[0:`AFU_LINE_W-1] <= buffer_in.write_data;
          end
        end
        default: ;  // Other tags are not stripe data
      endcase
    end
  end

  // Response marks a stripe read as fully delivered
  always_ff @(posedge clock) begin
    if (reset || clear) begin
      received1 <= 1'b0;
      received2 <= 1'b0;
    end else if (response.valid) begin
      if (response.tag == `TAG_STRIPE1) received1 <= 1'b1;
      if (response.tag == `TAG_STRIPE2) received2 <= 1'b1;
    end
  end

  assign both_done = received1 && received2;

  // Host must only return stripe data while the controller expects it
  a_stripe_write_captured: assert property (
    @(posedge clock) disable iff (reset)
    stripe_write |-> capture
  ) else $error("stripe_buffer: stripe write with capture low");

endmodule

//--- tb_parity_afu.sv
`timescale 1ns/1ns
`include "afu_params.svh"

module tb_parity_afu;

  import afu_pkg::*;

  localparam int JOBS           = 2;
  localparam int MAX_CHUNKS     = 3;
  localparam int MEM_LINES      = 64;
  localparam int TIMEOUT_CYCLES = JOBS * (MAX_CHUNKS + 2) * 60;

  logic        clock = 1'b0;
  logic        reset;
  logic        enabled;
  addr_t       wed;
  buffer_in_t  buffer_in;
  response_t   response;
  command_t    command;
  buffer_out_t buffer_out;

  logic [31:0] lcg_state = 32'd24641;
  int          errors = 0;
  int          checks = 0;
  int          cycle_count = 0;
  line_t       stripe1_model [0:2*MAX_CHUNKS-1];
  line_t       stripe2_model [0:2*MAX_CHUNKS-1];
  line_t       status_expect;

  parity_afu dut0 (
    .clock      (clock),
    .reset      (reset),
    .enabled    (enabled),
    .wed        (wed),
    .buffer_in  (buffer_in),
    .response   (response),
    .command    (command),
    .buffer_out (buffer_out)
  );

  host_model #(.MEM_LINES(MEM_LINES)) hm0 (
    .clock      (clock),
    .reset      (reset),
    .command    (command),
    .buffer_out (buffer_out),
    .buffer_in  (buffer_in),
    .response   (response)
  );

  always #4 clock = ~clock;

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout: no finish within %0d cycles, %0d errors so far",
               TIMEOUT_CYCLES, errors);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic line_t random_line();
    line_t l;
    for (int i = 0; i < 16; i++) begin
      l[i*32 +: 32] = lcg_next();
    end
    return l;
  endfunction

  // Host keeps descriptor words little-endian
  function automatic line_t put_word_le(input line_t line, input int first, input addr_t value);
    line_t result;
    result = line;
    for (int b = 0; b < 8; b++) begin
      result[(first + b)*8 +: 8] = 8'(value >> (8*b));
    end
    return result;
  endfunction

  function automatic int mem_index(input addr_t address);
    return int'((address >> 6) % MEM_LINES);
  endfunction

  function automatic command_t make_command(input logic [0:`AFU_CMD_W-1] code,
                                            input logic [0:`AFU_TAG_W-1] tag,
                                            input int size, input addr_t address);
    command_t c;
    c = '0;
    c.valid          = 1'b1;
    c.command        = code;
    c.command_parity = ($countones(code) % 2) == 0;  // Field plus bit is odd-weighted
    c.tag            = tag;
    c.tag_parity     = ($countones(tag) % 2) == 0;
    c.size           = `AFU_SIZE_W'(size);
    c.address        = address;
    c.address_parity = ($countones(address) % 2) == 0;
    return c;
  endfunction

  task automatic check_line(input string name, input line_t expected, input line_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_command(input string name, input command_t expected,
                               input command_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic setup_job(input int chunks, input addr_t wed_a, s1, s2, p);
    line_t desc_line;
    desc_line = '0;
    desc_line = put_word_le(desc_line, 0, addr_t'(chunks * `AFU_CHUNK_BYTES));
    desc_line = put_word_le(desc_line, 8, s1);
    desc_line = put_word_le(desc_line, 16, s2);
    desc_line = put_word_le(desc_line, 24, p);
    hm0.mem[mem_index(wed_a)] = desc_line;
    status_expect = desc_line;
    status_expect[`AFU_STATUS_OFFSET*8 +: 8] = 8'd1;
    for (int k = 0; k < 2*chunks; k++) begin
      stripe1_model[k] = random_line();
      stripe2_model[k] = random_line();
      hm0.mem[mem_index(s1) + k] = stripe1_model[k];
      hm0.mem[mem_index(s2) + k] = stripe2_model[k];
      hm0.mem[mem_index(p) + k]  = random_line();  // Stale data to be overwritten
    end
    hm0.cmd_count  = 0;
    hm0.read_count = 0;
  endtask

  task automatic check_job(input int j, input int chunks, input addr_t wed_a, s1, s2, p);
    command_t expected [0:3*MAX_CHUNKS+1];
    int       n;
    int       count;
    n = 0;
    expected[n] = make_command(`CMD_READ_CL_NA, `TAG_WED, 32, wed_a);
    n++;
    for (int k = 0; k < chunks; k++) begin
      expected[n] = make_command(`CMD_READ_CL_S, `TAG_STRIPE1, 128, s1 + k*128);
      n++;
      expected[n] = make_command(`CMD_READ_CL_S, `TAG_STRIPE2, 128, s2 + k*128);
      n++;
      expected[n] = make_command(`CMD_WRITE_MS, `TAG_PARITY, 128, p + k*128);
      n++;
    end
    expected[n] = make_command(`CMD_WRITE_MS, `TAG_DONE, 1, wed_a + `AFU_STATUS_OFFSET);
    n++;
    if (hm0.cmd_count != n) begin
      errors++;
      $display("Job %0d: host saw %0d commands but %0d were due", j, hm0.cmd_count, n);
    end
    count = (hm0.cmd_count < n) ? hm0.cmd_count : n;
    for (int i = 0; i < count; i++) begin
      check_command($sformatf("job %0d command %0d", j, i), expected[i], hm0.cmd_log[i]);
    end
    for (int k = 0; k < 2*chunks; k++) begin
      check_line($sformatf("job %0d parity line %0d", j, k),
                 stripe1_model[k] ^ stripe2_model[k], hm0.mem[mem_index(p) + k]);
    end
    if (hm0.read_count != 2*chunks + 2) begin
      errors++;
      $display("Job %0d: host made %0d buffer reads but %0d were due",
               j, hm0.read_count, 2*chunks + 2);
    end
    count = (hm0.read_count < 32) ? hm0.read_count : 32;
    for (int i = 0; i < count; i++) begin
      check_bit($sformatf("job %0d read parity %0d", j, i),
                ($countones(hm0.read_log[i].read_data) % 2) == 0,
                hm0.read_log[i].read_parity);
    end
    check_line($sformatf("job %0d status line", j), status_expect, hm0.mem[mem_index(wed_a)]);
  endtask

  task automatic run_job(input int j, input int chunks, input addr_t wed_a, s1, s2, p);
    setup_job(chunks, wed_a, s1, s2, p);
    wed     = wed_a;
    enabled = 1'b1;
    @(negedge clock);
    check_bit($sformatf("job %0d quiet 1 cycle after enable", j), 1'b0, command.valid);
    @(negedge clock);
    check_bit($sformatf("job %0d WED command 2 cycles after enable", j), 1'b1, command.valid);
    while (hm0.jobs_done < j + 1) @(posedge clock);
    @(negedge clock);
    check_job(j, chunks, wed_a, s1, s2, p);
    repeat (2) @(negedge clock);
    enabled = 1'b0;
    repeat (3) begin
      @(negedge clock);
      check_bit($sformatf("job %0d quiet while disabled", j), 1'b0, command.valid);
    end
  endtask

  initial begin
    reset   = 1'b1;
    enabled = 1'b0;
    wed     = '0;
    for (int i = 0; i < 64; i++) begin
      hm0.delays[i] = int'((lcg_next() >> 16) % 8);
    end
    repeat (3) @(negedge clock);
    reset = 1'b0;
    repeat (3) begin
      @(negedge clock);
      check_bit("valid after reset", 1'b0, command.valid);
      check_bit("command parity after reset", 1'b0, command.command_parity);
      check_bit("tag parity after reset", 1'b0, command.tag_parity);
      check_bit("address parity after reset", 1'b0, command.address_parity);
    end
    run_job(0, 3, 64'h0, 64'h100, 64'h300, 64'h500);
    // Upper address bits exercise full 64-bit arithmetic
    run_job(1, 1, 64'h80, 64'h0000_00A0_0000_0700, 64'h0000_00B0_0000_0800,
            64'h0000_00C0_0000_0900);
    $display("Checks run %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- write_path.sv
`timescale 1ns/1ns
`include "afu_params.svh"

module write_path (
  input  logic                 clock,
  input  logic                 reset,
  input  afu_pkg::chunk_t      stripe1,
  input  afu_pkg::chunk_t      stripe2,
  input  afu_pkg::buffer_in_t  buffer_in,
  output afu_pkg::buffer_out_t buffer_out
);

  import afu_pkg::*;

  chunk_t parity_chunk;
  line_t  status_line;
  line_t  selected;
  line_t  line_q;
  logic   parity_q;

  assign parity_chunk = stripe1 ^ stripe2;

  // Status write carries a single byte of 1
  always_comb begin
    status_line = '0;
    status_line[`AFU_STATUS_OFFSET*8 +: 8] = 8'd1;
  end

  always_comb begin
    if (buffer_in.read_tag == `TAG_DONE) begin
      selected = status_line;
    end else if (buffer_in.read_address) begin
      selected = parity_chunk[`AFU_LINE_W:`AFU_CHUNK_W-1];
    end else begin
      selected = parity_chunk[0:`AFU_LINE_W-1];
    end
  end

  // Fixed one-cycle read latency
  always_ff @(posedge clock) begin
    if (buffer_in.read_valid) begin
      line_q <= selected;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      parity_q <= 1'b0;
    end else if (buffer_in.read_valid) begin
      parity_q <= ~^selected;  // Odd parity over the half
    end
  end

  assign buffer_out = '{read_data: line_q, read_parity: parity_q};

endmodule
